// File: hdl/ifetch_pkg.sv
/*
 * Instruction fetch package
 * Address and word types, fetch FSM states and default sizes
 */
package ifetch_pkg;

  // Byte address, always word aligned here
  typedef logic [31:0] addr_t;

  // Instruction word as returned by memory
  typedef logic [31:0] word_t;

  // Fetch FSM states
  typedef enum logic [1:0] {
    FETCH_IDLE     = 2'd0,
    FETCH_RUN      = 2'd1,
    FETCH_DRAIN    = 2'd2,
    FETCH_ERR_HALT = 2'd3
  } fetch_state_e;

  // Max requests in flight on the memory port
  localparam int unsigned NumOutstandingDefault = 2;

  // Prefetch buffer entries, at least NumOutstanding
  localparam int unsigned BufDepthDefault = 4;

endpackage

// File: hdl/ifetch_ctrl_fsm.sv
/*
 * Fetch control FSM
 * Issues memory requests, tracks the fetch address, handles redirect, error halt and idle
 */
`timescale 1ns/10ps

module ifetch_ctrl_fsm import ifetch_pkg::*; (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  fetch_enable_i,
  input  addr_t boot_addr_i,
  input  logic  branch_i,
  input  addr_t branch_target_i,
  input  logic  instr_gnt_i,
  input  logic  resp_err_i,
  input  logic  space_ok_i,
  input  logic  buf_empty_i,
  input  logic  in_flight_zero_i,
  output logic  instr_req_o,
  output addr_t instr_addr_o,
  output logic  flush_o,
  output logic  idle_o
);

  fetch_state_e state_q, state_d;
  addr_t        addr_q;
  addr_t        redir_addr_q;
  logic         hold_q;
  logic         redir_pend_q;
  logic         boot_done_q;
  logic         granted;
  logic         req_wait;

  // A raised request stays up until it is granted
  assign instr_req_o  = hold_q || (state_q == FETCH_RUN && space_ok_i);
  assign granted      = instr_req_o && instr_gnt_i;
  assign req_wait     = instr_req_o && !instr_gnt_i;
  assign instr_addr_o = addr_q;

  // The old request granted after a branch is stale as well
  assign flush_o = branch_i || (redir_pend_q && granted);
  assign idle_o  = (state_q == FETCH_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: begin
        if (fetch_enable_i) begin
          state_d = FETCH_RUN;
        end
      end
      FETCH_RUN: begin
        if (resp_err_i) begin
          state_d = FETCH_ERR_HALT;
        end else if (!fetch_enable_i) begin
          state_d = FETCH_DRAIN;
        end
      end
      FETCH_DRAIN: begin
        if (resp_err_i) begin
          state_d = FETCH_ERR_HALT;
        end else if (fetch_enable_i) begin
          state_d = FETCH_RUN;
        end else if (in_flight_zero_i && buf_empty_i && !instr_req_o) begin
          state_d = FETCH_IDLE;
        end
      end
      FETCH_ERR_HALT: begin
        if (branch_i) begin
          state_d = fetch_enable_i ? FETCH_RUN : FETCH_DRAIN;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= FETCH_IDLE;
      addr_q       <= '0;
      hold_q       <= 1'b0;
      redir_pend_q <= 1'b0;
      boot_done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      hold_q  <= req_wait;
      if (branch_i) begin
        boot_done_q <= 1'b1;
        // Address must stay put while the old request waits
        if (req_wait) begin
          redir_pend_q <= 1'b1;
        end else begin
          addr_q       <= branch_target_i;
          redir_pend_q <= 1'b0;
        end
      end else if (granted) begin
        redir_pend_q <= 1'b0;
        addr_q       <= redir_pend_q ? redir_addr_q : addr_q + 32'd4;
      end else if (state_q == FETCH_IDLE && fetch_enable_i && !boot_done_q) begin
        addr_q      <= boot_addr_i;
        boot_done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (branch_i && req_wait) begin
      redir_addr_q <= branch_target_i;
    end
  end

endmodule

// File: hdl/ifetch_outstanding_cnt.sv
/*
 * Outstanding request counter
 * Tracks requests in flight and responses to drop after a redirect
 */
`timescale 1ns/10ps

module ifetch_outstanding_cnt import ifetch_pkg::*; #(
  parameter  int unsigned NumOutstanding = NumOutstandingDefault,
  localparam int unsigned CntW           = $clog2(NumOutstanding + 1)
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            grant_i,
  input  logic            rvalid_i,
  input  logic            flush_i,
  output logic [CntW-1:0] in_flight_o,
  output logic            keep_o,
  output logic            in_flight_zero_o
);

  logic [CntW-1:0] in_flight_q, in_flight_d;
  logic [CntW-1:0] discard_q, discard_d;

  always_comb begin
    in_flight_d = in_flight_q;
    if (grant_i && !rvalid_i) begin
      in_flight_d = in_flight_q + 1'b1;
    end else if (!grant_i && rvalid_i) begin
      in_flight_d = in_flight_q - 1'b1;
    end
  end

  // Everything still in flight after a flush belongs to the old stream
  always_comb begin
    discard_d = discard_q;
    if (flush_i) begin
      discard_d = in_flight_d;
    end else if (rvalid_i && discard_q != '0) begin
      discard_d = discard_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_flight_q <= '0;
      discard_q   <= '0;
    end else begin
      in_flight_q <= in_flight_d;
      discard_q   <= discard_d;
    end
  end

  assign in_flight_o      = in_flight_q;
  assign in_flight_zero_o = (in_flight_q == '0);
  assign keep_o           = !flush_i && (discard_q == '0);

endmodule

// File: hdl/ifetch_prefetch_buf.sv
/*
 * Prefetch buffer
 * FIFO of fetched words with address and error flag, plus a queue of granted addresses
 */
`timescale 1ns/10ps

module ifetch_prefetch_buf import ifetch_pkg::*; #(
  parameter  int unsigned NumOutstanding = NumOutstandingDefault,
  parameter  int unsigned BufDepth       = BufDepthDefault,
  localparam int unsigned FillW          = $clog2(BufDepth + 1)
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             flush_i,
  input  logic             grant_i,
  input  addr_t            grant_addr_i,
  input  logic             push_i,
  input  word_t            push_rdata_i,
  input  logic             push_err_i,
  input  logic             pop_i,
  output word_t            head_rdata_o,
  output addr_t            head_addr_o,
  output logic             head_err_o,
  output logic             empty_o,
  output logic [FillW-1:0] fill_o
);

  localparam int unsigned PtrW = (BufDepth > 1) ? $clog2(BufDepth) : 1;
  localparam int unsigned AqW  = (NumOutstanding > 1) ? $clog2(NumOutstanding) : 1;

  word_t             rdata_mem [BufDepth];
  addr_t             addr_mem  [BufDepth];
  logic [BufDepth-1:0] err_mem;
  logic [PtrW-1:0]   wr_ptr_q, rd_ptr_q;
  logic [FillW-1:0]  fill_q;

  // Granted addresses, in the order responses come back
  addr_t             aq_mem [NumOutstanding];
  logic [AqW-1:0]    aq_wr_q, aq_rd_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      aq_wr_q  <= '0;
      aq_rd_q  <= '0;
    end else if (flush_i) begin
      // Queued addresses all belong to responses that get discarded
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      aq_rd_q  <= aq_wr_q;
    end else begin
      if (grant_i) begin
        aq_wr_q <= (aq_wr_q == AqW'(NumOutstanding - 1)) ? '0 : aq_wr_q + 1'b1;
      end
      if (push_i) begin
        aq_rd_q  <= (aq_rd_q == AqW'(NumOutstanding - 1)) ? '0 : aq_rd_q + 1'b1;
        wr_ptr_q <= (wr_ptr_q == PtrW'(BufDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(BufDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        fill_q <= fill_q + 1'b1;
      end else if (!push_i && pop_i) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_i && !flush_i) begin
      aq_mem[aq_wr_q] <= grant_addr_i;
    end
    if (push_i && !flush_i) begin
      rdata_mem[wr_ptr_q] <= push_rdata_i;
      addr_mem[wr_ptr_q]  <= aq_mem[aq_rd_q];
      err_mem[wr_ptr_q]   <= push_err_i;
    end
  end

  assign head_rdata_o = rdata_mem[rd_ptr_q];
  assign head_addr_o  = addr_mem[rd_ptr_q];
  assign head_err_o   = err_mem[rd_ptr_q];
  assign empty_o      = (fill_q == '0);
  assign fill_o       = fill_q;

endmodule

// File: hdl/ifetch_handshake.sv
/*
 * Decode-side output stage
 * Holds one buffer entry and offers it over a four-phase req/ack handshake
 */
`timescale 1ns/10ps

module ifetch_handshake import ifetch_pkg::*; (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  empty_i,
  input  word_t head_rdata_i,
  input  addr_t head_addr_i,
  input  logic  head_err_i,
  input  logic  fetch_ack_i,
  output logic  pop_o,
  output logic  fetch_req_o,
  output word_t fetch_rdata_o,
  output addr_t fetch_addr_o,
  output logic  fetch_err_o
);

  logic  req_q;
  logic  ack_low_q;
  word_t rdata_q;
  addr_t addr_q;
  logic  err_q;
  logic  capture;

  // New item only after ack was seen low for a full cycle
  assign capture = !req_q && ack_low_q && !fetch_ack_i && !empty_i;
  assign pop_o   = capture;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q     <= 1'b0;
      ack_low_q <= 1'b0;
    end else begin
      ack_low_q <= !fetch_ack_i;
      if (capture) begin
        req_q <= 1'b1;
      end else if (req_q && fetch_ack_i) begin
        req_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      rdata_q <= head_rdata_i;
      addr_q  <= head_addr_i;
      err_q   <= head_err_i;
    end
  end

  assign fetch_req_o   = req_q;
  assign fetch_rdata_o = rdata_q;
  assign fetch_addr_o  = addr_q;
  assign fetch_err_o   = err_q;

endmodule

// File: hdl/ifetch_top.sv
/*
 * Instruction fetch subsystem top
 * Memory request port on one side, four-phase decode port on the other
 */
`timescale 1ns/10ps

module ifetch_top import ifetch_pkg::*; #(
  parameter int unsigned NumOutstanding = NumOutstandingDefault,
  parameter int unsigned BufDepth       = BufDepthDefault
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  fetch_enable_i,
  input  addr_t boot_addr_i,
  input  logic  branch_i,
  input  addr_t branch_target_i,
  output logic  idle_o,
  output logic  instr_req_o,
  output addr_t instr_addr_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  input  word_t instr_rdata_i,
  input  logic  instr_err_i,
  output logic  fetch_req_o,
  output word_t fetch_rdata_o,
  output addr_t fetch_addr_o,
  output logic  fetch_err_o,
  input  logic  fetch_ack_i
);

  localparam int unsigned InFlightW = $clog2(NumOutstanding + 1);
  localparam int unsigned FillW     = $clog2(BufDepth + 1);
  localparam int unsigned OccW      = $clog2(NumOutstanding + BufDepth + 1);

  logic                 mem_gnt;
  logic                 flush;
  logic                 keep;
  logic                 push;
  logic                 resp_err;
  logic                 space_ok;
  logic                 in_flight_zero;
  logic [InFlightW-1:0] in_flight;
  logic [FillW-1:0]     fill;
  logic [OccW-1:0]      occupancy;
  logic                 buf_empty;
  logic                 pop;
  word_t                head_rdata;
  addr_t                head_addr;
  logic                 head_err;

  assign mem_gnt  = instr_req_o && instr_gnt_i;
  assign push     = instr_rvalid_i && keep;
  assign resp_err = push && instr_err_i;

  // Every request in flight may still need a buffer slot
  assign occupancy = OccW'(in_flight) + OccW'(fill);
  assign space_ok  = (occupancy < OccW'(BufDepth)) &&
                     (in_flight < InFlightW'(NumOutstanding));

  ifetch_ctrl_fsm u_ctrl_fsm (
    .clk_i            (clk_i          ),
    .arst_n_i         (arst_n_i       ),
    .fetch_enable_i   (fetch_enable_i ),
    .boot_addr_i      (boot_addr_i    ),
    .branch_i         (branch_i       ),
    .branch_target_i  (branch_target_i),
    .instr_gnt_i      (instr_gnt_i    ),
    .resp_err_i       (resp_err       ),
    .space_ok_i       (space_ok       ),
    .buf_empty_i      (buf_empty      ),
    .in_flight_zero_i (in_flight_zero ),
    .instr_req_o      (instr_req_o    ),
    .instr_addr_o     (instr_addr_o   ),
    .flush_o          (flush          ),
    .idle_o           (idle_o         )
  );

  ifetch_outstanding_cnt #(
    .NumOutstanding (NumOutstanding)
  ) u_outstanding_cnt (
    .clk_i            (clk_i         ),
    .arst_n_i         (arst_n_i      ),
    .grant_i          (mem_gnt       ),
    .rvalid_i         (instr_rvalid_i),
    .flush_i          (flush         ),
    .in_flight_o      (in_flight     ),
    .keep_o           (keep          ),
    .in_flight_zero_o (in_flight_zero)
  );

  ifetch_prefetch_buf #(
    .NumOutstanding (NumOutstanding),
    .BufDepth       (BufDepth      )
  ) u_prefetch_buf (
    .clk_i        (clk_i        ),
    .arst_n_i     (arst_n_i     ),
    .flush_i      (flush        ),
    .grant_i      (mem_gnt      ),
    .grant_addr_i (instr_addr_o ),
    .push_i       (push         ),
    .push_rdata_i (instr_rdata_i),
    .push_err_i   (instr_err_i  ),
    .pop_i        (pop          ),
    .head_rdata_o (head_rdata   ),
    .head_addr_o  (head_addr    ),
    .head_err_o   (head_err     ),
    .empty_o      (buf_empty    ),
    .fill_o       (fill         )
  );

  // No capture while the buffer is being flushed
  ifetch_handshake u_handshake (
    .clk_i         (clk_i              ),
    .arst_n_i      (arst_n_i           ),
    .empty_i       (buf_empty || flush ),
    .head_rdata_i  (head_rdata         ),
    .head_addr_i   (head_addr          ),
    .head_err_i    (head_err           ),
    .fetch_ack_i   (fetch_ack_i        ),
    .pop_o         (pop                ),
    .fetch_req_o   (fetch_req_o        ),
    .fetch_rdata_o (fetch_rdata_o      ),
    .fetch_addr_o  (fetch_addr_o       ),
    .fetch_err_o   (fetch_err_o        )
  );

endmodule

// File: tests/ifetch_mem_model.sv
/*
 * Instruction memory responder
 * Grants word requests and answers them in order, with LCG-drawn delays
 */
`timescale 1ns/10ps

module ifetch_mem_model import ifetch_pkg::*; #(
  parameter logic [31:0] Seed     = 32'h3ea,
  parameter word_t       DataMask = 32'hA5A5_0000
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  req_i,
  input  addr_t addr_i,
  input  addr_t err_addr_i,
  output logic  gnt_o,
  output logic  rvalid_o,
  output word_t rdata_o,
  output logic  err_o
);

  logic [31:0] lcg_q     = Seed;
  logic [1:0]  gnt_wait  = 2'd0;
  logic [1:0]  resp_wait = 2'd0;
  logic        gnt_q     = 1'b0;
  logic        rvalid_q  = 1'b0;
  word_t       rdata_q   = '0;
  logic        err_q     = 1'b0;
  addr_t       pending [$];

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(negedge clk_i) begin
    addr_t resp_addr;
    if (!arst_n_i) begin
      gnt_q     = 1'b0;
      rvalid_q  = 1'b0;
      err_q     = 1'b0;
      gnt_wait  = 2'd0;
      resp_wait = 2'd0;
      pending.delete();
    end else begin
      // Answer older grants first, so a new grant waits at least a cycle
      rvalid_q = 1'b0;
      err_q    = 1'b0;
      if (pending.size() != 0) begin
        if (resp_wait == 2'd0) begin
          resp_addr = pending.pop_front();
          rvalid_q  = 1'b1;
          rdata_q   = resp_addr ^ DataMask;
          err_q     = (resp_addr == err_addr_i);
          lcg_q     = lcg_next(lcg_q);
          resp_wait = lcg_q[31:30];
        end else begin
          resp_wait = resp_wait - 2'd1;
        end
      end
      gnt_q = 1'b0;
      if (req_i) begin
        if (gnt_wait == 2'd0) begin
          gnt_q = 1'b1;
          pending.push_back(addr_i);
          lcg_q    = lcg_next(lcg_q);
          gnt_wait = lcg_q[31:30];
        end else begin
          gnt_wait = gnt_wait - 2'd1;
        end
      end
    end
  end

  assign gnt_o    = gnt_q;
  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = err_q;

endmodule

// File: tests/core_ifetch_tb_top.sv
/*
 * Instruction fetch testbench
 * Replays pattern steps on the fetch subsystem and checks every decode item
 */
`timescale 1ns/10ps

module core_ifetch_tb_top import ifetch_pkg::*; ();

  localparam int unsigned NumOutstanding = NumOutstandingDefault;
  localparam int unsigned BufDepth       = BufDepthDefault;
  localparam int          MaxSteps       = 32;
  localparam int          PatCols        = 5;
  localparam int          SettleCycles   = 48;
  localparam int          WordBound      = 16;
  localparam word_t       DataMask       = 32'hA5A5_0000;
  localparam addr_t       NoErr          = 32'hFFFF_FFFF;

  logic  clk = 1'b0;
  logic  arst_n;
  logic  fetch_enable;
  addr_t boot_addr;
  logic  branch;
  addr_t branch_target;
  logic  idle;
  logic  instr_req;
  addr_t instr_addr;
  logic  instr_gnt;
  logic  instr_rvalid;
  word_t instr_rdata;
  logic  instr_err;
  logic  fetch_req;
  word_t fetch_rdata;
  addr_t fetch_addr;
  logic  fetch_err;
  logic  fetch_ack;
  addr_t err_addr;

  logic [31:0] pat_mem [MaxSteps*PatCols];
  addr_t       next_addr;
  addr_t       cur_err;
  int          ack_delay;
  int          cycles      = 0;
  int          cycle_limit = 0;

  always #4 clk = ~clk;

  ifetch_top #(
    .NumOutstanding (NumOutstanding),
    .BufDepth       (BufDepth      )
  ) UUT (
    .clk_i           (clk          ),
    .arst_n_i        (arst_n       ),
    .fetch_enable_i  (fetch_enable ),
    .boot_addr_i     (boot_addr    ),
    .branch_i        (branch       ),
    .branch_target_i (branch_target),
    .idle_o          (idle         ),
    .instr_req_o     (instr_req    ),
    .instr_addr_o    (instr_addr   ),
    .instr_gnt_i     (instr_gnt    ),
    .instr_rvalid_i  (instr_rvalid ),
    .instr_rdata_i   (instr_rdata  ),
    .instr_err_i     (instr_err    ),
    .fetch_req_o     (fetch_req    ),
    .fetch_rdata_o   (fetch_rdata  ),
    .fetch_addr_o    (fetch_addr   ),
    .fetch_err_o     (fetch_err    ),
    .fetch_ack_i     (fetch_ack    )
  );

  ifetch_mem_model #(
    .Seed     (32'h3ea ),
    .DataMask (DataMask)
  ) u_mem_model (
    .clk_i      (clk         ),
    .arst_n_i   (arst_n      ),
    .req_i      (instr_req   ),
    .addr_i     (instr_addr  ),
    .err_addr_i (err_addr    ),
    .gnt_o      (instr_gnt   ),
    .rvalid_o   (instr_rvalid),
    .rdata_o    (instr_rdata ),
    .err_o      (instr_err   )
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("error at %0d ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      abort_run($sformatf("Timeout, the tests did not finish within %0d cycles", cycle_limit));
    end
  end

  task automatic wait_offer();
    do begin
      @(negedge clk);
    end while (!fetch_req);
  endtask

  // Called at a falling edge with fetch_req_o high
  task automatic serve_item();
    addr_t exp_addr;
    exp_addr = next_addr;
    check_addr("fetch_addr_o", fetch_addr, exp_addr);
    check_word("fetch_rdata_o", fetch_rdata, exp_addr ^ DataMask);
    check_bit("fetch_err_o", fetch_err, exp_addr == cur_err);
    repeat (ack_delay) @(negedge clk);
    check_bit("fetch_req_o before ack", fetch_req, 1'b1);
    check_addr("fetch_addr_o before ack", fetch_addr, exp_addr);
    fetch_ack = 1'b1;
    @(negedge clk);
    check_bit("fetch_req_o after ack", fetch_req, 1'b0);
    fetch_ack = 1'b0;
    next_addr = exp_addr + 32'd4;
  endtask

  // Only the items already in flight may follow the error item
  task automatic settle_after_error();
    int extra;
    extra = 0;
    repeat (SettleCycles) begin
      @(negedge clk);
      if (fetch_req) begin
        serve_item();
        extra++;
      end
    end
    if (extra >= int'(NumOutstanding)) begin
      abort_run($sformatf("Fetch went on after the error item, %0d more items came", extra));
    end
    check_bit("instr_req_o in error halt", instr_req, 1'b0);
  endtask

  task automatic run_stream(input int kind, input addr_t start, input int count,
                            input int ack, input addr_t err);
    // The stream ends with its error item
    if (err != NoErr && err >= start && err < start + 32'(4 * count)) begin
      count = int'((err - start) >> 2) + 1;
    end
    @(negedge clk);
    // Finish an item of the old stream that is already offered
    while (fetch_req) begin
      serve_item();
    end
    ack_delay    = ack;
    cur_err      = err;
    err_addr     = err;
    next_addr    = start;
    fetch_enable = 1'b1;
    if (kind == 1) begin
      boot_addr = start;
    end else begin
      branch        = 1'b1;
      branch_target = start;
    end
    @(negedge clk);
    branch = 1'b0;
    repeat (count) begin
      wait_offer();
      serve_item();
    end
    if (err != NoErr) begin
      settle_after_error();
    end
  endtask

  task automatic run_idle(input int ack);
    int extra;
    extra = 0;
    @(negedge clk);
    ack_delay    = ack;
    fetch_enable = 1'b0;
    do begin
      @(negedge clk);
      if (fetch_req) begin
        serve_item();
        extra++;
      end
    end while (!idle || fetch_req);
    if (extra > int'(BufDepth) + 1) begin
      abort_run($sformatf("Too many items after fetch was disabled, %0d came", extra));
    end
    repeat (SettleCycles) begin
      @(negedge clk);
      check_bit("idle_o after drain", idle, 1'b1);
      check_bit("instr_req_o while idle", instr_req, 1'b0);
      check_bit("fetch_req_o while idle", fetch_req, 1'b0);
    end
  endtask

  initial begin
    int    num_steps;
    int    base;
    int    kind;
    int    count;
    int    ack;
    addr_t start;
    addr_t err;
    arst_n        = 1'b0;
    fetch_enable  = 1'b0;
    boot_addr     = '0;
    branch        = 1'b0;
    branch_target = '0;
    fetch_ack     = 1'b0;
    err_addr      = NoErr;
    cur_err       = NoErr;
    next_addr     = '0;
    ack_delay     = 0;
    $readmemh("tests/ifetch_patterns.txt", pat_mem);
    num_steps = 0;
    while (num_steps < MaxSteps && pat_mem[num_steps*PatCols] != 32'd0) begin
      base        = num_steps * PatCols;
      count       = int'(pat_mem[base+2]);
      ack         = int'(pat_mem[base+3]);
      cycle_limit = cycle_limit + (count + int'(BufDepth) + 2) * (ack + WordBound) +
                    2 * SettleCycles;
      num_steps++;
    end
    if (num_steps == 0) begin
      abort_run("No test steps found in tests/ifetch_patterns.txt");
    end
    cycle_limit = cycle_limit + 200;

    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_bit("instr_req_o after reset", instr_req, 1'b0);
    check_bit("fetch_req_o after reset", fetch_req, 1'b0);
    check_bit("idle_o after reset", idle, 1'b1);

    for (int s = 0; s < num_steps; s++) begin
      base  = s * PatCols;
      kind  = int'(pat_mem[base]);
      start = pat_mem[base+1];
      count = int'(pat_mem[base+2]);
      ack   = int'(pat_mem[base+3]);
      err   = pat_mem[base+4];
      if (kind == 1 || kind == 2) begin
        run_stream(kind, start, count, ack, err);
      end else if (kind == 3) begin
        run_idle(ack);
      end else begin
        abort_run($sformatf("Pattern step %0d has an unknown kind %0d", s, kind));
      end
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: tests/ifetch_patterns.txt
// kind addr count ack_delay err_addr, all hex, FFFFFFFF means no error
// kind 1 boot, 2 redirect, 3 disable and wait for idle, 0 ends the list
1 00001000 0C 1 FFFFFFFF
2 00002040 08 0 FFFFFFFF
2 00003000 10 0C FFFFFFFF
2 00004000 06 2 00004014
2 00005000 0A 3 FFFFFFFF
3 00000000 00 1 FFFFFFFF
2 00006100 08 0 FFFFFFFF
2 00007000 05 1 00007010
2 00008000 06 6 FFFFFFFF
2 00009ff0 0C 0 FFFFFFFF
3 00000000 00 0 FFFFFFFF
2 0000a000 04 2 0000a000
2 0000b000 07 1 FFFFFFFF
3 00000000 00 4 FFFFFFFF
0 00000000 00 0 FFFFFFFF

// File: all.f
hdl/ifetch_pkg.sv
hdl/ifetch_ctrl_fsm.sv
hdl/ifetch_outstanding_cnt.sv
hdl/ifetch_prefetch_buf.sv
hdl/ifetch_handshake.sv
hdl/ifetch_top.sv
tests/ifetch_mem_model.sv
tests/core_ifetch_tb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the fetch testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module core_ifetch_tb_top -f all.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vcore_ifetch_tb_top)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Testbench passed" <<< "$sim_out"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
